// File: Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
RTL_TOP   ?= core
FILELIST  ?= core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall -Wno-fatal --timing --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary --timing -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: core.f
src/mips_pkg.sv
src/fetch.sv
src/reg_file.sv
src/decode.sv
src/execute.sv
src/mem_stage.sv
src/core.sv
tests/core_checker.sv
tests/core_tb.sv

// File: src/core.sv
`timescale 1ns/1ns
`default_nettype none

module core (
	input  logic            i_clk,
	input  logic            i_reset,
	input  mips_pkg::word_t i_instr,
	input  mips_pkg::word_t i_read_data,
	output mips_pkg::word_t o_instr_addr,
	output mips_pkg::word_t o_data_addr,
	output mips_pkg::word_t o_write_data,
	output logic            o_mem_write,
	output logic            o_mem_read
);
	import mips_pkg::*;

	word_t   pc;
	if_id_t  if_id;
	id_ex_t  id_ex;
	ex_mem_t ex_mem;
	wb_t     wb;
	logic    branch_taken;

	assign o_instr_addr = pc;
	assign o_data_addr  = ex_mem.alu_result;
	assign o_write_data = ex_mem.rt_data;
	assign o_mem_write  = ex_mem.mem_write;
	assign o_mem_read   = ex_mem.mem_read;

	fetch u_fetch (
		.i_clk           (i_clk),
		.i_reset         (i_reset),
		.i_instr         (i_instr),
		.i_branch_taken  (branch_taken),
		.i_branch_target (ex_mem.branch_target),
		.o_pc            (pc),
		.o_if_id         (if_id)
	);

	decode u_decode (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_if_id (if_id),
		.i_wb    (wb),
		.o_id_ex (id_ex)
	);

	execute u_execute (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_id_ex  (id_ex),
		.o_ex_mem (ex_mem)
	);

	// read data arrives in the same cycle as the address.
	mem_stage u_mem_stage (
		.i_clk          (i_clk),
		.i_reset        (i_reset),
		.i_ex_mem       (ex_mem),
		.i_read_data    (i_read_data),
		.o_branch_taken (branch_taken),
		.o_wb           (wb)
	);

endmodule

`default_nettype wire

// File: src/decode.sv
`timescale 1ns/1ns
`default_nettype none

module decode (
	input  logic             i_clk,
	input  logic             i_reset,
	input  mips_pkg::if_id_t i_if_id,
	input  mips_pkg::wb_t    i_wb,
	output mips_pkg::id_ex_t o_id_ex
);
	import mips_pkg::*;

	logic [5:0]  opcode;
	reg_addr_t   rs;
	reg_addr_t   rt;
	reg_addr_t   rd;
	logic [15:0] imm16;
	logic [5:0]  funct;
	ctrl_t       ctrl;
	word_t       rs_data;
	word_t       rt_data;
	id_ex_t      id_ex_d;

	assign opcode = i_if_id.instr[31:26];
	assign rs     = i_if_id.instr[25:21];
	assign rt     = i_if_id.instr[20:16];
	assign rd     = i_if_id.instr[15:11];
	assign imm16  = i_if_id.instr[15:0];
	assign funct  = i_if_id.instr[5:0];

	// main control.
	always_comb begin
		ctrl = '0;
		case (opcode)
			OP_RTYPE: begin
				ctrl.reg_dst   = 1'b1;
				ctrl.alu_kind  = KIND_FUNCT;
				ctrl.reg_write = 1'b1;
			end
			OP_ADDI: begin
				ctrl.alu_src   = 1'b1;
				ctrl.alu_kind  = KIND_ADD;
				ctrl.reg_write = 1'b1;
			end
			OP_LW: begin
				ctrl.alu_src    = 1'b1;
				ctrl.alu_kind   = KIND_ADD;
				ctrl.mem_read   = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.reg_write  = 1'b1;
			end
			OP_SW: begin
				ctrl.alu_src   = 1'b1;
				ctrl.alu_kind  = KIND_ADD;
				ctrl.mem_write = 1'b1;
			end
			OP_BEQ: begin
				ctrl.alu_kind = KIND_SUB;
				ctrl.branch   = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

	reg_file u_reg_file (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_rs      (rs),
		.i_rt      (rt),
		.i_wb      (i_wb),
		.o_rs_data (rs_data),
		.o_rt_data (rt_data)
	);

	always_comb begin
		id_ex_d.ctrl    = ctrl;
		id_ex_d.next_pc = i_if_id.next_pc;
		id_ex_d.rs_data = rs_data;
		id_ex_d.rt_data = rt_data;
		id_ex_d.imm     = {{16{imm16[15]}}, imm16};
		id_ex_d.rt      = rt;
		id_ex_d.rd      = rd;
		id_ex_d.funct   = funct;
	end

	always_ff @(posedge i_clk) begin
		o_id_ex <= id_ex_d;
		if (i_reset) begin
			o_id_ex.ctrl <= '0;
		end
	end

endmodule

`default_nettype wire

// File: src/execute.sv
`timescale 1ns/1ns
`default_nettype none

module execute (
	input  logic              i_clk,
	input  logic              i_reset,
	input  mips_pkg::id_ex_t  i_id_ex,
	output mips_pkg::ex_mem_t o_ex_mem
);
	import mips_pkg::*;

	alu_op_t alu_op;
	word_t   op_a;
	word_t   op_b;
	word_t   result;
	ex_mem_t ex_mem_d;

	// alu control.
	always_comb begin
		alu_op = ALU_ADD;
		case (i_id_ex.ctrl.alu_kind)
			KIND_SUB: alu_op = ALU_SUB;
			KIND_FUNCT: begin
				case (i_id_ex.funct)
					FN_SUB:  alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_SLT:  alu_op = ALU_SLT;
					default: alu_op = ALU_ADD;
				endcase
			end
			default: alu_op = ALU_ADD;
		endcase
	end

	assign op_a = i_id_ex.rs_data;
	assign op_b = i_id_ex.ctrl.alu_src ? i_id_ex.imm : i_id_ex.rt_data;

	always_comb begin
		case (alu_op)
			ALU_SUB: result = op_a - op_b;
			ALU_AND: result = op_a & op_b;
			ALU_OR:  result = op_a | op_b;
			ALU_SLT: result = {31'b0, $signed(op_a) < $signed(op_b)};
			default: result = op_a + op_b;
		endcase
	end

	always_comb begin
		ex_mem_d.branch        = i_id_ex.ctrl.branch;
		ex_mem_d.mem_read      = i_id_ex.ctrl.mem_read;
		ex_mem_d.mem_write     = i_id_ex.ctrl.mem_write;
		ex_mem_d.mem_to_reg    = i_id_ex.ctrl.mem_to_reg;
		ex_mem_d.reg_write     = i_id_ex.ctrl.reg_write;
		ex_mem_d.branch_target = i_id_ex.next_pc + {i_id_ex.imm[29:0], 2'b00};
		ex_mem_d.zero          = (result == '0);
		ex_mem_d.alu_result    = result;
		ex_mem_d.rt_data       = i_id_ex.rt_data;
		ex_mem_d.dest          = i_id_ex.ctrl.reg_dst ? i_id_ex.rd : i_id_ex.rt;
	end

	always_ff @(posedge i_clk) begin
		o_ex_mem <= ex_mem_d;
		if (i_reset) begin
			o_ex_mem.branch     <= 1'b0;
			o_ex_mem.mem_read   <= 1'b0;
			o_ex_mem.mem_write  <= 1'b0;
			o_ex_mem.mem_to_reg <= 1'b0;
			o_ex_mem.reg_write  <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: src/fetch.sv
`timescale 1ns/1ns
`default_nettype none

module fetch (
	input  logic             i_clk,
	input  logic             i_reset,
	input  mips_pkg::word_t  i_instr,
	input  logic             i_branch_taken,
	input  mips_pkg::word_t  i_branch_target,
	output mips_pkg::word_t  o_pc,
	output mips_pkg::if_id_t o_if_id
);
	import mips_pkg::*;

	word_t pc;
	word_t pc_plus4;

	assign pc_plus4 = pc + 32'd4;
	assign o_pc = pc;

	// taken branch comes back from the memory stage.
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			pc <= RESET_PC;
		end else if (i_branch_taken) begin
			pc <= i_branch_target;
		end else begin
			pc <= pc_plus4;
		end
	end

	// a cleared instruction is a nop.
	always_ff @(posedge i_clk) begin
		o_if_id.next_pc <= pc_plus4;
		if (i_reset) begin
			o_if_id.instr <= '0;
		end else begin
			o_if_id.instr <= i_instr;
		end
	end

endmodule

`default_nettype wire

// File: src/mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage (
	input  logic              i_clk,
	input  logic              i_reset,
	input  mips_pkg::ex_mem_t i_ex_mem,
	input  mips_pkg::word_t   i_read_data,
	output logic              o_branch_taken,
	output mips_pkg::wb_t     o_wb
);
	import mips_pkg::*;

	word_t     wb_read_data;
	word_t     wb_alu_result;
	reg_addr_t wb_dest;
	logic      wb_mem_to_reg;
	logic      wb_reg_write;

	// beq compares by subtraction, so zero means equal.
	assign o_branch_taken = i_ex_mem.branch & i_ex_mem.zero;

	always_ff @(posedge i_clk) begin
		wb_read_data  <= i_read_data;
		wb_alu_result <= i_ex_mem.alu_result;
		wb_dest       <= i_ex_mem.dest;
		if (i_reset) begin
			wb_mem_to_reg <= 1'b0;
			wb_reg_write  <= 1'b0;
		end else begin
			wb_mem_to_reg <= i_ex_mem.mem_to_reg;
			wb_reg_write  <= i_ex_mem.reg_write;
		end
	end

	// write-back select.
	assign o_wb.reg_write = wb_reg_write;
	assign o_wb.dest      = wb_dest;
	assign o_wb.data      = wb_mem_to_reg ? wb_read_data : wb_alu_result;

endmodule

`default_nettype wire

// File: src/mips_pkg.sv
`default_nettype none

package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [2:0] alu_op_t;

	localparam alu_op_t ALU_ADD = 3'd0;
	localparam alu_op_t ALU_SUB = 3'd1;
	localparam alu_op_t ALU_AND = 3'd2;
	localparam alu_op_t ALU_OR  = 3'd3;
	localparam alu_op_t ALU_SLT = 3'd4;

	// alu_kind values carried in ctrl_t.
	localparam logic [1:0] KIND_ADD   = 2'd0;
	localparam logic [1:0] KIND_SUB   = 2'd1;
	localparam logic [1:0] KIND_FUNCT = 2'd2;

	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;
	localparam logic [5:0] OP_BEQ   = 6'h04;

	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	localparam word_t RESET_PC = 32'h0000_0000;

	typedef struct packed {
		logic       reg_dst;
		logic       alu_src;
		logic [1:0] alu_kind;
		logic       branch;
		logic       mem_read;
		logic       mem_write;
		logic       mem_to_reg;
		logic       reg_write;
	} ctrl_t;

	typedef struct packed {
		word_t instr;
		word_t next_pc;
	} if_id_t;

	typedef struct packed {
		ctrl_t      ctrl;
		word_t      next_pc;
		word_t      rs_data;
		word_t      rt_data;
		word_t      imm;
		reg_addr_t  rt;
		reg_addr_t  rd;
		logic [5:0] funct;
	} id_ex_t;

	typedef struct packed {
		logic      branch;
		logic      mem_read;
		logic      mem_write;
		logic      mem_to_reg;
		logic      reg_write;
		word_t     branch_target;
		logic      zero;
		word_t     alu_result;
		word_t     rt_data;
		reg_addr_t dest;
	} ex_mem_t;

	typedef struct packed {
		logic      reg_write;
		reg_addr_t dest;
		word_t     data;
	} wb_t;

endpackage

`default_nettype wire

// File: src/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
	input  logic                i_clk,
	input  logic                i_reset,
	input  mips_pkg::reg_addr_t i_rs,
	input  mips_pkg::reg_addr_t i_rt,
	input  mips_pkg::wb_t       i_wb,
	output mips_pkg::word_t     o_rs_data,
	output mips_pkg::word_t     o_rt_data
);
	import mips_pkg::*;

	word_t regs [32];

	// write-through so a same-cycle write is visible.
	function automatic word_t read_reg(input reg_addr_t addr);
		word_t value;
		if (addr == '0) begin
			value = '0;
		end else if (i_wb.reg_write && i_wb.dest == addr) begin
			value = i_wb.data;
		end else begin
			value = regs[addr];
		end
		return value;
	endfunction

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wb.reg_write && i_wb.dest != '0) begin
			regs[i_wb.dest] <= i_wb.data;
		end
	end

	always_comb begin
		o_rs_data = read_reg(i_rs);
		o_rt_data = read_reg(i_rt);
	end

endmodule

`default_nettype wire

// File: tests/core_checker.sv
`timescale 1ns/1ns
`default_nettype none

module core_checker (
	input logic            i_clk,
	input logic            i_reset,
	input mips_pkg::word_t i_instr_addr,
	input mips_pkg::word_t i_data_addr,
	input mips_pkg::word_t i_write_data,
	input logic            i_mem_write,
	input logic            i_mem_read
);
	import mips_pkg::*;

	word_t st_addr [$];
	word_t st_data [$];
	word_t ld_addr [$];
	word_t br_pc [$];
	word_t br_target [$];
	word_t hist [5];
	logic  reset_d = 1'b0;
	int    errors = 0;
	int    test_start_errors = 0;

	task automatic clear();
		st_addr.delete();
		st_data.delete();
		ld_addr.delete();
		br_pc.delete();
		br_target.delete();
		test_start_errors = errors;
	endtask

	task automatic add_store(input word_t addr, input word_t data);
		st_addr.push_back(addr);
		st_data.push_back(data);
	endtask

	task automatic add_load(input word_t addr);
		ld_addr.push_back(addr);
	endtask

	task automatic add_branch(input word_t pc, input word_t target);
		br_pc.push_back(pc);
		br_target.push_back(target);
	endtask

	task automatic fail_value(input string name, input word_t exp, input word_t got);
		$display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
		errors++;
	endtask

	task automatic end_test(input int num, input string name);
		if (st_addr.size() != 0) begin
			$display("test %0d: %0d stores never happened", num, st_addr.size());
			errors++;
		end
		if (ld_addr.size() != 0) begin
			$display("test %0d: %0d loads never happened", num, ld_addr.size());
			errors++;
		end
		if (br_pc.size() != 0) begin
			$display("test %0d: branch at %h never reached its target", num, br_pc[0]);
			errors++;
		end
		$display("test %0d %s: %s (%0d errors)", num, name,
			(errors == test_start_errors) ? "ok" : "bad", errors - test_start_errors);
	endtask

	// sampled on the falling edge, away from the DUT updates.
	always @(negedge i_clk) begin
		if (reset_d) begin
			if (i_mem_write || i_mem_read) begin
				$display("t=%0t memory strobe active during reset", $time);
				errors++;
			end
			if (i_instr_addr != RESET_PC) begin
				fail_value("o_instr_addr", RESET_PC, i_instr_addr);
			end
		end
		if (i_reset) begin
			for (int i = 0; i < 5; i++) begin
				hist[i] = '1;
			end
		end else begin
			if (i_mem_write) begin
				if (st_addr.size() == 0) begin
					$display("t=%0t unexpected store to address %h", $time, i_data_addr);
					errors++;
				end else begin
					if (i_data_addr != st_addr[0]) begin
						fail_value("o_data_addr", st_addr[0], i_data_addr);
					end
					if (i_write_data != st_data[0]) begin
						fail_value("o_write_data", st_data[0], i_write_data);
					end
					void'(st_addr.pop_front());
					void'(st_data.pop_front());
				end
			end
			if (i_mem_read) begin
				if (ld_addr.size() == 0) begin
					$display("t=%0t unexpected load from address %h", $time, i_data_addr);
					errors++;
				end else begin
					if (i_data_addr != ld_addr[0]) begin
						fail_value("o_data_addr", ld_addr[0], i_data_addr);
					end
					void'(ld_addr.pop_front());
				end
			end
			for (int i = 4; i > 0; i--) begin
				hist[i] = hist[i-1];
			end
			hist[0] = i_instr_addr;
			// target is due four cycles after the branch.
			if (br_pc.size() != 0 && hist[4] == br_pc[0]) begin
				if (i_instr_addr != br_target[0]) begin
					fail_value("o_instr_addr", br_target[0], i_instr_addr);
				end
				void'(br_pc.pop_front());
				void'(br_target.pop_front());
			end
		end
		reset_d <= i_reset;
	end

endmodule

`default_nettype wire

// File: tests/core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module core_tb;
	import mips_pkg::*;

	logic  clk = 1'b0;
	logic  reset;
	word_t instr;
	word_t read_data;
	word_t instr_addr;
	word_t data_addr;
	word_t write_data;
	logic  mem_write;
	logic  mem_read;
	word_t prog [256];
	word_t ram [256];
	int    prog_n;
	word_t seed = 32'h6d88ba65;
	int    cycles = 0;
	int    limit = 30;
	string names [6] = '{"reset", "r-type alu", "immediates and r0",
		"loads and stores", "branches", "mixed"};

	always #2 clk = ~clk;

	core core_i (
		.i_clk        (clk),
		.i_reset      (reset),
		.i_instr      (instr),
		.i_read_data  (read_data),
		.o_instr_addr (instr_addr),
		.o_data_addr  (data_addr),
		.o_write_data (write_data),
		.o_mem_write  (mem_write),
		.o_mem_read   (mem_read)
	);

	core_checker chk (
		.i_clk        (clk),
		.i_reset      (reset),
		.i_instr_addr (instr_addr),
		.i_data_addr  (data_addr),
		.i_write_data (write_data),
		.i_mem_write  (mem_write),
		.i_mem_read   (mem_read)
	);

	// rom reads nop past its end.
	assign instr = (instr_addr < 32'd1024) ? prog[instr_addr[9:2]] : '0;
	assign read_data = ram[data_addr[9:2]];

	always @(posedge clk) begin
		if (mem_write) begin
			ram[data_addr[9:2]] <= write_data;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > limit) begin
			$display("timeout after %0d cycles, DUT never finished the program", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	function automatic word_t xorshift(input word_t x);
		word_t y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic word_t rnd();
		seed = xorshift(seed);
		return seed;
	endfunction

	function automatic word_t fill_word(input int i);
		return {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
	endfunction

	function automatic word_t rtype(input logic [5:0] fn, input int rd, input int rs, input int rt);
		return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
	endfunction

	function automatic word_t itype(input logic [5:0] op, input int rs, input int rt,
			input int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic logic [5:0] pick_fn();
		case (rnd() % 5)
			0: return FN_ADD;
			1: return FN_SUB;
			2: return FN_AND;
			3: return FN_OR;
			default: return FN_SLT;
		endcase
	endfunction

	// every real instruction is followed by three nops.
	task automatic emit(input word_t ins);
		prog[prog_n] = ins;
		prog_n += 4;
	endtask

	task automatic gen_program(input int kind);
		int body;
		int sel;
		int hi;
		int m;
		for (int i = 0; i < 256; i++) begin
			prog[i] = '0;
		end
		prog_n = 0;
		body = (kind == 1) ? 4 : 12 + int'(rnd() % 12);
		for (int k = 0; k < body; k++) begin
			case (kind)
				2: sel = (k < 6) ? 1 : 0;
				3: sel = (k % 2 == 0) ? 4 : 5;
				4: sel = (k < 6) ? 1 : 2;
				5: sel = (k < 4 || rnd() % 2 == 0) ? 6 : 3;
				6: sel = int'(rnd() % 4);
				default: sel = 1;
			endcase
			hi = (k + 3 < body) ? k + 3 : body;
			m = k + 1 + int'(rnd() % (hi - k));
			case (sel)
				0: emit(rtype(pick_fn(), 1 + rnd() % 15, 1 + rnd() % 15, 1 + rnd() % 15));
				1: emit(itype(OP_ADDI, rnd() % 16, 1 + rnd() % 15, rnd()));
				2: emit(itype((rnd() % 2) ? OP_SW : OP_LW, 0, 1 + rnd() % 15, (rnd() % 128) * 4));
				3: emit(itype(OP_BEQ, 1 + rnd() % 3, 1 + rnd() % 3, 4 * (m - k) - 1));
				4: emit(itype(OP_ADDI, rnd() % 8, (rnd() % 4 == 0) ? 0 : 1 + rnd() % 7,
					-(1 + int'(rnd() % 3000))));
				5: emit(rtype(pick_fn(), (rnd() % 3 == 0) ? 0 : 1 + rnd() % 7,
					rnd() % 8, rnd() % 8));
				default: emit(itype(OP_ADDI, 0, 1 + rnd() % 3, rnd() % 2));
			endcase
		end
		for (int r = 0; r < 32; r++) begin
			emit(itype(OP_SW, 0, r, 512 + 4 * r));
		end
	endtask

	// sequential instruction-set model.
	task automatic run_model();
		word_t regs [32];
		word_t mem [256];
		word_t ins;
		word_t imm;
		word_t a;
		word_t b;
		word_t ea;
		int    pc;
		for (int i = 0; i < 256; i++) begin
			mem[i] = fill_word(i);
		end
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		pc = 0;
		while (pc < prog_n) begin
			ins = prog[pc];
			imm = {{16{ins[15]}}, ins[15:0]};
			a = regs[ins[25:21]];
			b = regs[ins[20:16]];
			ea = a + imm;
			pc++;
			case (ins[31:26])
				OP_RTYPE: begin
					case (ins[5:0])
						FN_ADD: regs[ins[15:11]] = a + b;
						FN_SUB: regs[ins[15:11]] = a - b;
						FN_AND: regs[ins[15:11]] = a & b;
						FN_OR:  regs[ins[15:11]] = a | b;
						FN_SLT: regs[ins[15:11]] = ($signed(a) < $signed(b)) ? 1 : 0;
						default: ;
					endcase
				end
				OP_ADDI: regs[ins[20:16]] = ea;
				OP_LW: begin
					regs[ins[20:16]] = mem[ea[9:2]];
					chk.add_load(ea);
				end
				OP_SW: begin
					mem[ea[9:2]] = b;
					chk.add_store(ea, b);
				end
				OP_BEQ: begin
					if (a == b) begin
						chk.add_branch((pc - 1) * 4, (pc + int'(imm)) * 4);
						pc = pc + int'(imm);
					end
				end
				default: ;
			endcase
			regs[0] = '0;
		end
	endtask

	initial begin
		reset = 1'b1;
		for (int t = 1; t <= 6; t++) begin
			reset <= 1'b1;
			@(posedge clk);
			chk.clear();
			gen_program(t);
			for (int i = 0; i < 256; i++) begin
				ram[i] = fill_word(i);
			end
			run_model();
			limit = limit + prog_n + 20 + 10;
			repeat (9) @(posedge clk);
			reset <= 1'b0;
			while (instr_addr < prog_n * 4 + 16) begin
				@(posedge clk);
			end
			chk.end_test(t, names[t-1]);
		end
		$display("tests run: 6, errors: %0d", chk.errors);
		if (chk.errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
